//--- verif/clint_slice_tests.txt
# columns: mode op addr data exp_data exp_irq (hex; irq bits are timer, software, external)
# mode 0 single command, 1 mtime read bounded below by exp_data, 2 burst under back-pressure
0 0 0000 0000000000000000 0000000000000000 0
0 0 b000 0 0 0
0 0 4000 0 ffffffffffffffff 0
0 1 0000 a5a5a5a500000003 0 2
0 0 0000 0 1 2
0 1 b000 00000000ffff0001 0 3
0 0 b000 0 1 3
0 1 0000 2 0 1
0 0 0000 0 0 1
0 1 4000 123456789abcdef0 0 1
0 0 4000 0 123456789abcdef0 1
0 1 b000 0 0 0
0 0 b000 0 0 0
0 1 bff8 1000 0 0
0 1 4000 1000 0 4
1 0 bff8 0 1000 4
0 0 4000 0 1000 4
0 1 4000 ffffffffffffffff 0 0
1 0 bff8 0 1000 0
0 0 0008 0 0 0
0 1 0008 1 0 0
0 0 0000 0 0 0
0 1 4008 0 0 0
0 0 4000 0 ffffffffffffffff 0
0 1 bff0 5 0 0
0 0 bff0 0 0 0
0 1 b004 1 0 0
0 0 b004 0 0 0
0 0 b000 0 0 0
0 1 0000 1 0 2
2 0 0000 0 1 2
2 0 b000 0 0 2
2 0 4000 0 ffffffffffffffff 2
2 0 0010 0 0 2
2 0 0000 0 1 2
2 0 4000 0 ffffffffffffffff 2
2 0 b000 0 0 2
2 0 1234 0 0 2
0 1 0000 0 0 0
0 0 0000 0 0 0

//--- sources.f
verilog/clint_pkg.sv
verilog/clint_msg_fifo.sv
verilog/clint_mtime.sv
verilog/clint_csr_block.sv
verilog/clint_slice.sv
verif/clint_slice_properties.sv
verif/clint_slice_tb.sv

//--- verif/clint_slice_tb.sv
`default_nettype none

module clint_slice_tb;

   import clint_pkg::*;

   localparam int CMD_DEPTH  = 2;
   localparam int RESP_DEPTH = 2;
   localparam int MTIME_DIV  = 8;
   localparam int BURST_MAX  = CMD_DEPTH + RESP_DEPTH + 1;

   typedef struct packed {
      logic timer;
      logic software;
      logic external;
   } irq_s;

   // mode 0 is a single command, 1 an mtime read with a lower bound, 2 a burst member.
   typedef struct packed {
      logic [1:0]         mode;
      clint_cmd_s         cmd;
      logic [DWORD_W-1:0] exp_data;
      irq_s               exp_irq;
   } test_s;

   logic        clk_i;
   logic        rst_i;
   clint_cmd_s  cmd_i;
   logic        cmd_valid_i;
   logic        cmd_ready_o;
   clint_resp_s resp_o;
   logic        resp_valid_o;
   logic        resp_ready_i;
   logic        timer_irq_o;
   logic        software_irq_o;
   logic        external_irq_o;

   test_s tests[$];
   int    sb_q[$];
   int    err_count;
   int    pass_count;
   int    fail_count;
   logic  tests_loaded;

   clint_slice #(
      .CMD_DEPTH  (CMD_DEPTH),
      .RESP_DEPTH (RESP_DEPTH),
      .MTIME_DIV  (MTIME_DIV)
   ) uut (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cmd_i          (cmd_i),
      .cmd_valid_i    (cmd_valid_i),
      .cmd_ready_o    (cmd_ready_o),
      .resp_o         (resp_o),
      .resp_valid_o   (resp_valid_o),
      .resp_ready_i   (resp_ready_i),
      .timer_irq_o    (timer_irq_o),
      .software_irq_o (software_irq_o),
      .external_irq_o (external_irq_o)
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #2 clk_i = ~clk_i;
      end
   end

   task automatic check_resp(input clint_resp_s got, input clint_resp_s exp);
      if (got !== exp) begin
         $display("mismatch at %0t: resp_o got %h expected %h", $time, got, exp);
         err_count++;
      end
   endtask

   task automatic check_mtime(input clint_resp_s got, input clint_resp_s lo,
                              input logic [DWORD_W-1:0] hi);
      if (got.op !== lo.op || got.addr !== lo.addr || $isunknown(got.data) ||
          got.data < lo.data || got.data > hi) begin
         $display("mismatch at %0t: resp_o got %h expected %h with data up to %h",
                  $time, got, lo, hi);
         err_count++;
      end
   endtask

   task automatic check_irq(input irq_s got, input irq_s exp);
      if (got !== exp) begin
         $display("mismatch at %0t: {timer,software,external}_irq_o got %b expected %b",
                  $time, got, exp);
         err_count++;
      end
   endtask

   function automatic int load_tests();
      int                 fd;
      int                 n;
      string              line;
      int                 mode;
      logic               op;
      clint_addr_t        addr;
      logic [DWORD_W-1:0] data;
      logic [DWORD_W-1:0] exp_data;
      logic [2:0]         irq;
      test_s              t;
      fd = $fopen("verif/clint_slice_tests.txt", "r");
      if (fd == 0) begin
         return 0;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line[0] != "#") begin
            n = $sscanf(line, "%d %h %h %h %h %h", mode, op, addr, data, exp_data, irq);
            if (n == 6) begin
               t.mode     = mode[1:0];
               t.cmd.op   = clint_op_e'(op);
               t.cmd.addr = addr;
               t.cmd.data = data;
               t.exp_data = exp_data;
               t.exp_irq  = irq;
               tests.push_back(t);
            end
         end
      end
      $fclose(fd);
      return tests.size();
   endfunction

   // consecutive burst lines go out back to back, everything else waits for an idle slice.
   function automatic logic can_send(input int idx);
      if (idx >= tests.size()) begin
         return 1'b0;
      end
      if (sb_q.size() == 0) begin
         return 1'b1;
      end
      return (tests[idx].mode == 2'd2) && (idx > 0) && (tests[idx-1].mode == 2'd2);
   endfunction

   initial begin : main
      int                 ntests;
      int                 next_idx;
      int                 cycle;
      int                 set_cycle;
      int                 burst_cnt;
      int                 idx;
      int                 errs_before;
      logic               hold_low;
      logic               cmd_taken;
      logic               burst_end;
      clint_resp_s        exp;
      irq_s               got_irq;
      logic [DWORD_W-1:0] hi;

      rst_i        = 1'b1;
      cmd_i        = '0;
      cmd_valid_i  = 1'b0;
      resp_ready_i = 1'b0;
      err_count    = 0;
      pass_count   = 0;
      fail_count   = 0;
      tests_loaded = 1'b0;
      next_idx     = 0;
      cycle        = 0;
      set_cycle    = 0;
      burst_cnt    = 0;
      hold_low     = 1'b0;
      cmd_taken    = 1'b0;
      void'($urandom(32'h1bf3_72d3));
      ntests = load_tests();
      if (ntests == 0) begin
         $display("could not read any test from verif/clint_slice_tests.txt");
         $display("FAIL: see errors above");
         $finish;
      end else begin
         tests_loaded = 1'b1;
         repeat (4) @(posedge clk_i);
         @(negedge clk_i);
         rst_i = 1'b0;
         while (pass_count + fail_count < ntests) begin
            @(negedge clk_i);
            cycle++;
            if (cmd_valid_i && cmd_taken) begin
               next_idx++;
               cmd_valid_i = 1'b0;
            end
            if (!cmd_valid_i && can_send(next_idx)) begin
               if (tests[next_idx].mode == 2'd2 &&
                   (next_idx == 0 || tests[next_idx-1].mode != 2'd2)) begin
                  hold_low  = 1'b1;
                  burst_cnt = 0;
               end
               cmd_i       = tests[next_idx].cmd;
               cmd_valid_i = 1'b1;
            end
            resp_ready_i = hold_low ? 1'b0 : ($urandom_range(3) != 0);

            // outputs come from registers, so this cycle's transfers are known now.
            cmd_taken = cmd_valid_i && cmd_ready_o;
            burst_end = (next_idx + 1 >= ntests) || (tests[next_idx+1].mode != 2'd2);
            if (cmd_taken) begin
               sb_q.push_back(next_idx);
               if (cmd_i.op == clint_op_wr && cmd_i.addr == MTIME_ADDR) begin
                  set_cycle = cycle;
               end
               if (hold_low) begin
                  burst_cnt++;
               end
            end
            if (hold_low && cmd_valid_i && !cmd_ready_o) begin
               $display("back-pressure: cmd_ready_o fell after %0d commands", burst_cnt);
               if (burst_cnt > BURST_MAX) begin
                  $display("cmd_ready_o fell too late, limit is %0d commands", BURST_MAX);
                  err_count++;
               end
               hold_low = 1'b0;
            end else if (hold_low && cmd_taken && burst_end) begin
               $display("cmd_ready_o stayed high through a burst of %0d commands", burst_cnt);
               err_count++;
               hold_low = 1'b0;
            end

            if (resp_valid_o && resp_ready_i) begin
               if (sb_q.size() == 0) begin
                  $display("a response arrived at %0t with no command outstanding", $time);
                  err_count++;
               end else begin
                  idx         = sb_q.pop_front();
                  errs_before = err_count;
                  exp = '{op:   tests[idx].cmd.op,
                          addr: tests[idx].cmd.addr,
                          data: tests[idx].exp_data};
                  if (tests[idx].mode == 2'd1) begin
                     hi = tests[idx].exp_data + DWORD_W'((cycle - set_cycle) / MTIME_DIV + 1);
                     check_mtime(resp_o, exp, hi);
                  end else begin
                     check_resp(resp_o, exp);
                  end
                  got_irq = '{timer:    timer_irq_o,
                              software: software_irq_o,
                              external: external_irq_o};
                  check_irq(got_irq, tests[idx].exp_irq);
                  if (err_count == errs_before) begin
                     pass_count++;
                  end else begin
                     fail_count++;
                  end
                  $display("test %0d %s addr %h: %s", idx, exp.op.name(), exp.addr,
                           (err_count == errs_before) ? "ok" : "wrong");
               end
            end
         end
         // assertion failures in the bound checker count as errors too.
         err_count += uut.u_props.assert_fails;
         $display("tests %0d, ok %0d, wrong %0d, errors %0d",
                  ntests, pass_count, fail_count, err_count);
         if (err_count == 0) begin
            $display("PASS: all tests");
         end else begin
            $display("FAIL: see errors above");
         end
         $finish;
      end
   end

   initial begin : watchdog
      int limit;
      wait (tests_loaded === 1'b1);
      limit = tests.size() * (CMD_DEPTH + RESP_DEPTH + 20) + 100;
      repeat (limit) @(posedge clk_i);
      $display("the run timed out after %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/clint_slice_properties.sv
`default_nettype none

module clint_slice_properties (
   input wire                             clk_i,
   input wire                             rst_i,
   input wire clint_pkg::clint_cmd_s      cmd_i,
   input wire                             cmd_valid_i,
   input wire                             cmd_ready_i,
   input wire clint_pkg::clint_resp_s     resp_i,
   input wire                             resp_valid_i,
   input wire                             resp_ready_i,
   input wire                             timer_irq_i,
   input wire [clint_pkg::DWORD_W-1:0]    mtime_i,
   input wire [clint_pkg::DWORD_W-1:0]    mtimecmp_i
);

   int assert_fails = 0;

   // a stalled request keeps its valid and its payload until it is taken.
   property cmd_held_p;
      @(posedge clk_i) disable iff (rst_i)
         (cmd_valid_i && !cmd_ready_i) |=> (cmd_valid_i && $stable(cmd_i));
   endproperty

   property resp_held_p;
      @(posedge clk_i) disable iff (rst_i)
         (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_i));
   endproperty

   // the timer line is a plain level compare of the two counters.
   property timer_level_p;
      @(posedge clk_i) disable iff (rst_i)
         timer_irq_i == (mtime_i >= mtimecmp_i);
   endproperty

   a_cmd_held: assert property (cmd_held_p)
      else begin
         assert_fails++;
         $error("cmd_i changed while waiting for cmd_ready_o");
      end

   a_resp_held: assert property (resp_held_p)
      else begin
         assert_fails++;
         $error("resp_o dropped or changed before it was accepted");
      end

   a_timer_level: assert property (timer_level_p)
      else begin
         assert_fails++;
         $error("timer_irq_o does not follow mtime >= mtimecmp");
      end

endmodule

bind clint_slice clint_slice_properties u_props (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .cmd_i        (cmd_i),
   .cmd_valid_i  (cmd_valid_i),
   .cmd_ready_i  (cmd_ready_o),
   .resp_i       (resp_o),
   .resp_valid_i (resp_valid_o),
   .resp_ready_i (resp_ready_i),
   .timer_irq_i  (timer_irq_o),
   .mtime_i      (mtime),
   .mtimecmp_i   (u_csr.mtimecmp_q)
);

`default_nettype wire

//--- verilog/clint_slice.sv
`default_nettype none

module clint_slice #(
   parameter int CMD_DEPTH  = 2,
   parameter int RESP_DEPTH = 2,
   parameter int MTIME_DIV  = 8
) (
   input  wire                        clk_i,
   input  wire                        rst_i,

   input  wire clint_pkg::clint_cmd_s cmd_i,
   input  wire                        cmd_valid_i,
   output logic                       cmd_ready_o,

   output clint_pkg::clint_resp_s     resp_o,
   output logic                       resp_valid_o,
   input  wire                        resp_ready_i,

   output logic                       timer_irq_o,
   output logic                       software_irq_o,
   output logic                       external_irq_o
);

   import clint_pkg::*;

   clint_cmd_s         cmd_head;
   logic               cmd_head_valid;
   logic               cmd_pop;
   clint_resp_s        resp_new;
   logic               resp_slot_ready;
   logic               mtime_set;
   logic [DWORD_W-1:0] mtime_set_val;
   logic [DWORD_W-1:0] mtime;

   clint_msg_fifo #(
      .payload_t (clint_cmd_s),
      .DEPTH     (CMD_DEPTH)
   ) u_cmd_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (cmd_i),
      .valid_i (cmd_valid_i),
      .ready_o (cmd_ready_o),
      .data_o  (cmd_head),
      .valid_o (cmd_head_valid),
      .ready_i (cmd_pop)
   );

   // the pop that retires a command is also the push of its response.
   clint_csr_block u_csr (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cmd_i           (cmd_head),
      .cmd_valid_i     (cmd_head_valid),
      .cmd_pop_o       (cmd_pop),
      .resp_o          (resp_new),
      .resp_ready_i    (resp_slot_ready),
      .mtime_i         (mtime),
      .mtime_set_o     (mtime_set),
      .mtime_set_val_o (mtime_set_val),
      .timer_irq_o     (timer_irq_o),
      .software_irq_o  (software_irq_o),
      .external_irq_o  (external_irq_o)
   );

   clint_msg_fifo #(
      .payload_t (clint_resp_s),
      .DEPTH     (RESP_DEPTH)
   ) u_resp_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .data_i  (resp_new),
      .valid_i (cmd_pop),
      .ready_o (resp_slot_ready),
      .data_o  (resp_o),
      .valid_o (resp_valid_o),
      .ready_i (resp_ready_i)
   );

   clint_mtime #(
      .MTIME_DIV (MTIME_DIV)
   ) u_mtime (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .set_i     (mtime_set),
      .set_val_i (mtime_set_val),
      .mtime_o   (mtime)
   );

endmodule

`default_nettype wire

//--- verilog/clint_csr_block.sv
`default_nettype none

module clint_csr_block (
   input  wire                             clk_i,
   input  wire                             rst_i,

   input  wire clint_pkg::clint_cmd_s      cmd_i,
   input  wire                             cmd_valid_i,
   output logic                            cmd_pop_o,

   output clint_pkg::clint_resp_s          resp_o,
   input  wire                             resp_ready_i,

   input  wire [clint_pkg::DWORD_W-1:0]    mtime_i,
   output logic                            mtime_set_o,
   output logic [clint_pkg::DWORD_W-1:0]   mtime_set_val_o,

   output logic                            timer_irq_o,
   output logic                            software_irq_o,
   output logic                            external_irq_o
);

   import clint_pkg::*;

   logic               is_wr;
   logic               do_wr;
   logic               sel_msip;
   logic               sel_mtimecmp;
   logic               sel_meip;
   logic               sel_mtime;
   logic [DWORD_W-1:0] rdata;
   logic [DWORD_W-1:0] mtimecmp_q;
   logic               msip_q;
   logic               meip_q;

   assign is_wr = (cmd_i.op == clint_op_wr);

   // the head command retires only when its response has a slot to go to.
   assign cmd_pop_o = cmd_valid_i & resp_ready_i;
   assign do_wr     = cmd_pop_o & is_wr;

   always_comb begin
      sel_msip     = 1'b0;
      sel_mtimecmp = 1'b0;
      sel_meip     = 1'b0;
      sel_mtime    = 1'b0;
      rdata        = '0;
      case (cmd_i.addr)
         MSIP_ADDR: begin
            sel_msip = 1'b1;
            rdata    = DWORD_W'(msip_q);
         end
         MTIMECMP_ADDR: begin
            sel_mtimecmp = 1'b1;
            rdata        = mtimecmp_q;
         end
         MEIP_ADDR: begin
            sel_meip = 1'b1;
            rdata    = DWORD_W'(meip_q);
         end
         MTIME_ADDR: begin
            sel_mtime = 1'b1;
            rdata     = mtime_i;
         end
         default: begin
            // unmapped addresses read as zero.
            rdata = '0;
         end
      endcase
   end

   // mtime itself lives in the timer, this block only asks it to load.
   assign mtime_set_o     = do_wr & sel_mtime;
   assign mtime_set_val_o = cmd_i.data;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mtimecmp_q <= '1;
         msip_q     <= 1'b0;
         meip_q     <= 1'b0;
      end else if (do_wr) begin
         if (sel_mtimecmp) begin
            mtimecmp_q <= cmd_i.data;
         end
         if (sel_msip) begin
            msip_q <= cmd_i.data[0];
         end
         if (sel_meip) begin
            meip_q <= cmd_i.data[0];
         end
      end
   end

   assign resp_o = '{op:   cmd_i.op,
                     addr: cmd_i.addr,
                     data: is_wr ? '0 : rdata};

   assign timer_irq_o    = (mtime_i >= mtimecmp_q);
   assign software_irq_o = msip_q;
   assign external_irq_o = meip_q;

endmodule

`default_nettype wire

//--- verilog/clint_mtime.sv
`default_nettype none

module clint_mtime #(
   parameter int MTIME_DIV = 8
) (
   input  wire                             clk_i,
   input  wire                             rst_i,

   input  wire                             set_i,
   input  wire [clint_pkg::DWORD_W-1:0]    set_val_i,
   output logic [clint_pkg::DWORD_W-1:0]   mtime_o
);

   localparam int             DIV_W    = $clog2(MTIME_DIV);
   localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(MTIME_DIV - 1);

   logic [DIV_W-1:0] div_cnt;
   logic             tick;

   if (MTIME_DIV < 2) begin : g_div_check
      $error("clint_mtime: MTIME_DIV must be at least 2");
   end

   // the divider counts DIV_LOAD down to zero, so one tick per MTIME_DIV cycles.
   assign tick = (div_cnt == '0);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         div_cnt <= DIV_LOAD;
         mtime_o <= '0;
      end else if (set_i) begin
         // a software write wins over a pending tick and restarts the divider.
         div_cnt <= DIV_LOAD;
         mtime_o <= set_val_i;
      end else if (tick) begin
         div_cnt <= DIV_LOAD;
         mtime_o <= mtime_o + 1'b1;
      end else begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/clint_msg_fifo.sv
`default_nettype none

module clint_msg_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 2
) (
   input  wire      clk_i,
   input  wire      rst_i,

   input  wire payload_t data_i,
   input  wire      valid_i,
   output logic     ready_o,

   output payload_t data_o,
   output logic     valid_o,
   input  wire      ready_i
);

   // a single-entry buffer still needs a one-bit pointer.
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign ready_o = (count != CNT_W'(DEPTH));
   assign valid_o = (count != '0);
   assign push    = valid_i & ready_o;
   assign pop     = valid_o & ready_i;
   assign data_o  = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // a push and a pop in the same cycle leave the occupancy alone.
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= data_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/clint_pkg.sv
`default_nettype none

package clint_pkg;

   // command operation carried in the first field of every message.
   typedef enum logic {
      clint_op_rd = 1'b0,
      clint_op_wr = 1'b1
   } clint_op_e;

   // device-local byte address.
   typedef logic [15:0] clint_addr_t;

   localparam int DWORD_W = 64;

   // register map of the slice. Anything else reads as zero.
   localparam clint_addr_t MSIP_ADDR     = 16'h0000;
   localparam clint_addr_t MTIMECMP_ADDR = 16'h4000;
   localparam clint_addr_t MEIP_ADDR     = 16'hb000;
   localparam clint_addr_t MTIME_ADDR    = 16'hbff8;

   // every write carries a full dword, so there is no size field.
   typedef struct packed {
      clint_op_e          op;
      clint_addr_t        addr;
      logic [DWORD_W-1:0] data;
   } clint_cmd_s;

   // data holds the read value on a read and zero on a write.
   typedef struct packed {
      clint_op_e          op;
      clint_addr_t        addr;
      logic [DWORD_W-1:0] data;
   } clint_resp_s;

endpackage

`default_nettype wire
